//--- blake_mix_pkg.sv
`default_nettype none

package blake_mix_pkg;

	localparam int NUM_WORDS = 16;

	typedef logic [63:0] word_t;
	typedef logic [3:0] word_idx_t;

	// word selection for one G step
	typedef struct packed {
		word_idx_t a;
		word_idx_t b;
		word_idx_t c;
		word_idx_t d;
	} g_sched_t;

	// columns first, then diagonals
	localparam g_sched_t G_SCHEDULE [8] = '{
		'{4'd0, 4'd4, 4'd8,  4'd12},
		'{4'd1, 4'd5, 4'd9,  4'd13},
		'{4'd2, 4'd6, 4'd10, 4'd14},
		'{4'd3, 4'd7, 4'd11, 4'd15},
		'{4'd0, 4'd5, 4'd10, 4'd15},
		'{4'd1, 4'd6, 4'd11, 4'd12},
		'{4'd2, 4'd7, 4'd8,  4'd13},
		'{4'd3, 4'd4, 4'd9,  4'd14}
	};

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
	} quad_t;

	// one committed 64-bit host write
	typedef struct packed {
		logic      valid;
		word_idx_t idx;
		word_t     data;
	} host_wr_t;

	typedef struct packed {
		logic [11:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [11:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	localparam logic [11:0] ADDR_CTRL       = 12'h000;
	localparam logic [11:0] ADDR_STATUS     = 12'h004;
	localparam logic [11:0] ADDR_STATE_BASE = 12'h100;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- output_register_element.sv
`timescale 1ns/1ps
`default_nettype none

module output_register_element
	import blake_mix_pkg::*;
(
	input  wire        clk_i,
	input  wire        rst_n_i,
	input  wire        write_i,
	input  wire word_t state_i,
	output word_t      state_o
);

	// one state word, loaded only when its write bit is set
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_o <= '0;
		end else if (write_i) begin
			state_o <= state_i;
		end
	end

endmodule

`default_nettype wire

//--- output_register_block.sv
`timescale 1ns/1ps
`default_nettype none

module output_register_block
	import blake_mix_pkg::*;
(
	input  wire                                 clk_i,
	input  wire                                 rst_n_i,
	input  wire [NUM_WORDS-1:0]                 write_bits_i,
	input  wire [NUM_WORDS*$bits(word_t)-1:0]   input_i,
	output wire [NUM_WORDS*$bits(word_t)-1:0]   output_o
);

	localparam int WORD_W = $bits(word_t);

	// word i lives at bits 64i .. 64i+63
	for (genvar i = 0; i < NUM_WORDS; i++) begin : g_word
		output_register_element output_register_element_i (
			.clk_i   (clk_i),
			.rst_n_i (rst_n_i),
			.write_i (write_bits_i[i]),
			.state_i (input_i[i*WORD_W +: WORD_W]),
			.state_o (output_o[i*WORD_W +: WORD_W])
		);
	end

endmodule

`default_nettype wire

//--- g_mix.sv
`timescale 1ns/1ps
`default_nettype none

module g_mix
	import blake_mix_pkg::*;
(
	input  wire quad_t quad_i,
	output quad_t      quad_o
);

	localparam int unsigned R0 = 32;
	localparam int unsigned R1 = 24;
	localparam int unsigned R2 = 16;
	localparam int unsigned R3 = 63;

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (64 - n));
	endfunction

	word_t a1;
	word_t b1;
	word_t c1;
	word_t d1;
	word_t a2;
	word_t b2;
	word_t c2;
	word_t d2;

	// first half, message word taken as zero
	assign a1 = quad_i.a + quad_i.b;
	assign d1 = rotr(quad_i.d ^ a1, R0);
	assign c1 = quad_i.c + d1;
	assign b1 = rotr(quad_i.b ^ c1, R1);

	// second half
	assign a2 = a1 + b1;
	assign d2 = rotr(d1 ^ a2, R2);
	assign c2 = c1 + d2;
	assign b2 = rotr(b1 ^ c2, R3);

	assign quad_o = '{a: a2, b: b2, c: c2, d: d2};

endmodule

`default_nettype wire

//--- mix_round_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mix_round_ctrl
	import blake_mix_pkg::*;
#(
	parameter int unsigned ROUNDS = 12
) (
	input  wire                                 clk_i,
	input  wire                                 rst_n_i,
	input  wire                                 start_i,
	input  wire host_wr_t                       host_wr_i,
	output g_sched_t                            sched_o,
	input  wire quad_t                          mix_i,
	output logic [NUM_WORDS-1:0]                write_bits_o,
	output logic [NUM_WORDS*$bits(word_t)-1:0]  input_o,
	output logic                                busy_o
);

	localparam int RW = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
	localparam logic [RW-1:0] LAST_ROUND = RW'(ROUNDS - 1);
	localparam int unsigned MIX_CYCLES = 8 * ROUNDS;

	logic          busy_q;
	logic [2:0]    step_q;
	logic [RW-1:0] round_q;
	word_t [NUM_WORDS-1:0] in_words;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			step_q  <= '0;
			round_q <= '0;
		end else if (busy_q) begin
			// step wraps from 7 back to 0 on its own
			step_q <= step_q + 3'd1;
			if (step_q == 3'd7) begin
				if (round_q == LAST_ROUND) begin
					busy_q  <= 1'b0;
					round_q <= '0;
				end else begin
					round_q <= round_q + 1'b1;
				end
			end
		end else if (start_i) begin
			busy_q  <= 1'b1;
			step_q  <= '0;
			round_q <= '0;
		end
	end

	assign sched_o = G_SCHEDULE[step_q];
	assign busy_o  = busy_q;

	// mix results win over host writes
	always_comb begin
		write_bits_o = '0;
		in_words     = '0;
		if (busy_q) begin
			write_bits_o[sched_o.a] = 1'b1;
			write_bits_o[sched_o.b] = 1'b1;
			write_bits_o[sched_o.c] = 1'b1;
			write_bits_o[sched_o.d] = 1'b1;
			in_words[sched_o.a]     = mix_i.a;
			in_words[sched_o.b]     = mix_i.b;
			in_words[sched_o.c]     = mix_i.c;
			in_words[sched_o.d]     = mix_i.d;
		end else if (host_wr_i.valid) begin
			write_bits_o[host_wr_i.idx] = 1'b1;
			in_words[host_wr_i.idx]     = host_wr_i.data;
		end
	end

	assign input_o = in_words;

	// slave must refuse state writes while a mix is running
	a_host_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		host_wr_i.valid |-> $onehot(write_bits_o));

	a_busy_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(busy_q) |-> ##(MIX_CYCLES) !busy_q);

endmodule

`default_nettype wire

//--- axil_state_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_state_regs
	import blake_mix_pkg::*;
(
	input  wire                                 clk_i,
	input  wire                                 rst_n_i,
	input  wire axil_req_t                      s_axil_req_i,
	output axil_rsp_t                           s_axil_rsp_o,
	input  wire                                 busy_i,
	input  wire [NUM_WORDS*$bits(word_t)-1:0]   state_i,
	output host_wr_t                            host_wr_o,
	output logic                                start_o
);

	logic        bvalid_q;
	logic        rvalid_q;
	logic [1:0]  bresp_q;
	logic [1:0]  rresp_q;
	logic [31:0] rdata_q;
	logic [31:0] stage_q;

	logic        wr_hs;
	logic        rd_hs;
	logic        aw_state;
	logic        ar_state;
	logic        wr_err;
	logic        rd_err;
	logic [31:0] rd_data;
	word_t       rd_word;
	word_t [NUM_WORDS-1:0] state_words;

	assign state_words = state_i;

	// AW and W are taken in the same beat
	assign wr_hs = s_axil_req_i.awvalid & s_axil_req_i.wvalid & ~bvalid_q;
	assign rd_hs = s_axil_req_i.arvalid & ~rvalid_q;

	// state window 0x100..0x17f, word aligned
	assign aw_state = (s_axil_req_i.awaddr[11:7] == ADDR_STATE_BASE[11:7]) &&
		(s_axil_req_i.awaddr[1:0] == 2'b00);
	assign ar_state = (s_axil_req_i.araddr[11:7] == ADDR_STATE_BASE[11:7]) &&
		(s_axil_req_i.araddr[1:0] == 2'b00);

	always_comb begin
		wr_err          = 1'b1;
		start_o         = 1'b0;
		host_wr_o.valid = 1'b0;
		host_wr_o.idx   = s_axil_req_i.awaddr[6:3];
		host_wr_o.data  = {s_axil_req_i.wdata, stage_q};
		if (wr_hs) begin
			if (s_axil_req_i.awaddr == ADDR_CTRL) begin
				wr_err  = busy_i;
				start_o = ~busy_i & s_axil_req_i.wdata[0];
			end else if (aw_state) begin
				wr_err = busy_i;
				// high half commits the staged pair
				host_wr_o.valid = ~busy_i & s_axil_req_i.awaddr[2];
			end
		end
	end

	assign rd_word = state_words[s_axil_req_i.araddr[6:3]];

	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		if (s_axil_req_i.araddr == ADDR_STATUS) begin
			rd_data = {31'd0, busy_i};
		end else if (ar_state) begin
			rd_data = s_axil_req_i.araddr[2] ? rd_word[63:32] : rd_word[31:0];
		end else if (s_axil_req_i.araddr != ADDR_CTRL) begin
			rd_err = 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_hs) begin
				bvalid_q <= 1'b1;
			end else if (s_axil_req_i.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_hs) begin
				rvalid_q <= 1'b1;
			end else if (s_axil_req_i.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_hs) begin
			bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end
		if (wr_hs && aw_state && !busy_i && !s_axil_req_i.awaddr[2]) begin
			stage_q <= s_axil_req_i.wdata;
		end
		if (rd_hs) begin
			rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
			rdata_q <= rd_data;
		end
	end

	assign s_axil_rsp_o = '{
		awready: ~bvalid_q,
		wready:  ~bvalid_q,
		bresp:   bresp_q,
		bvalid:  bvalid_q,
		arready: ~rvalid_q,
		rdata:   rdata_q,
		rresp:   rresp_q,
		rvalid:  rvalid_q
	};

	// a pending response holds until the host takes it
	a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bvalid_q && !s_axil_req_i.bready |=> bvalid_q && $stable(bresp_q));

endmodule

`default_nettype wire

//--- blake_mix_top.sv
`timescale 1ns/1ps
`default_nettype none

module blake_mix_top
	import blake_mix_pkg::*;
#(
	parameter int unsigned ROUNDS = 12
) (
	input  wire            clk_i,
	input  wire            rst_n_i,
	input  wire axil_req_t s_axil_req_i,
	output axil_rsp_t      s_axil_rsp_o,
	output logic           busy_o
);

	host_wr_t                          host_wr;
	logic                              start;
	logic                              busy;
	g_sched_t                          sched;
	quad_t                             mix_in;
	quad_t                             mix_out;
	logic [NUM_WORDS-1:0]              write_bits;
	logic [NUM_WORDS*$bits(word_t)-1:0] blk_in;
	wire  [NUM_WORDS*$bits(word_t)-1:0] blk_out;
	word_t [NUM_WORDS-1:0]             state_words;

	axil_state_regs axil_state_regs0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.s_axil_req_i (s_axil_req_i),
		.s_axil_rsp_o (s_axil_rsp_o),
		.busy_i       (busy),
		.state_i      (blk_out),
		.host_wr_o    (host_wr),
		.start_o      (start)
	);

	mix_round_ctrl #(
		.ROUNDS (ROUNDS)
	) mix_round_ctrl0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.start_i      (start),
		.host_wr_i    (host_wr),
		.sched_o      (sched),
		.mix_i        (mix_out),
		.write_bits_o (write_bits),
		.input_o      (blk_in),
		.busy_o       (busy)
	);

	// pick the four operands of the current step
	assign state_words = blk_out;
	assign mix_in = '{
		a: state_words[sched.a],
		b: state_words[sched.b],
		c: state_words[sched.c],
		d: state_words[sched.d]
	};

	g_mix g_mix0 (
		.quad_i (mix_in),
		.quad_o (mix_out)
	);

	output_register_block output_register_block0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.write_bits_i (write_bits),
		.input_i      (blk_in),
		.output_o     (blk_out)
	);

	assign busy_o = busy;

endmodule

`default_nettype wire

//--- tb_blake_mix.sv
`timescale 1ns/1ps
`default_nettype none

module tb_blake_mix
	import blake_mix_pkg::*;
;

	localparam int unsigned ROUNDS = 2;
	localparam int unsigned MIX_CYCLES = 8 * ROUNDS;
	localparam int CLK_PERIOD = 4;
	// worst case per transaction including the longest bready or rready stall
	localparam int XACT_CYCLES = 16;
	localparam int NUM_XACTS = 220;
	localparam int NUM_RUNS = 3;
	localparam int TIMEOUT_NS =
		(NUM_XACTS * XACT_CYCLES + NUM_RUNS * 16 * ROUNDS + 20) * CLK_PERIOD;
	localparam logic [31:0] LFSR_SEED = 32'hd859_08dd;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        busy;
	logic        stall_en;
	axil_req_t   req;
	axil_rsp_t   rsp;
	logic [31:0] lfsr = LFSR_SEED;
	word_t       model_state [NUM_WORDS];
	int unsigned busy_cycles;

	blake_mix_top #(
		.ROUNDS (ROUNDS)
	) dut0 (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.s_axil_req_i (req),
		.s_axil_rsp_o (rsp),
		.busy_o       (busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic report_error(input string msg);
		$display("FAIL %0d ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// galois lfsr, one step per output bit
	function automatic logic [63:0] rand_bits(input int unsigned n);
		logic [63:0] r;
		r = '0;
		for (int unsigned k = 0; k < n; k++) begin
			r = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic word_t rotate_right(input word_t x, input int unsigned n);
		return (x >> n) | (x << (64 - n));
	endfunction

	// shadow of the engine, all rounds at once
	task automatic model_mix();
		g_sched_t s;
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		for (int r = 0; r < int'(ROUNDS); r++) begin
			for (int st = 0; st < 8; st++) begin
				s = G_SCHEDULE[3'(st)];
				a = model_state[s.a];
				b = model_state[s.b];
				c = model_state[s.c];
				d = model_state[s.d];
				a = a + b;
				d = rotate_right(d ^ a, 32);
				c = c + d;
				b = rotate_right(b ^ c, 24);
				a = a + b;
				d = rotate_right(d ^ a, 16);
				c = c + d;
				b = rotate_right(b ^ c, 63);
				model_state[s.a] = a;
				model_state[s.b] = b;
				model_state[s.c] = c;
				model_state[s.d] = d;
			end
		end
	endtask

	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
		int stall;
		@(posedge clk);
		req.awaddr  <= addr;
		req.awvalid <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= 4'hf;
		req.wvalid  <= 1'b1;
		@(negedge clk);
		while (!(rsp.awready && rsp.wready)) @(negedge clk);
		@(posedge clk);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		@(negedge clk);
		while (!rsp.bvalid) @(negedge clk);
		if (rsp.bresp !== exp_resp) begin
			report_error($sformatf("bresp %0d on write to %03h, expected %0d",
				rsp.bresp, addr, exp_resp));
		end
		stall = stall_en ? int'(rand_bits(3)) : 0;
		repeat (stall) @(posedge clk);
		@(posedge clk);
		req.bready <= 1'b1;
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [11:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp);
		int stall;
		@(posedge clk);
		req.araddr  <= addr;
		req.arvalid <= 1'b1;
		@(negedge clk);
		while (!rsp.arready) @(negedge clk);
		@(posedge clk);
		req.arvalid <= 1'b0;
		@(negedge clk);
		while (!rsp.rvalid) @(negedge clk);
		if (rsp.rresp !== exp_resp || rsp.rdata !== exp_data) begin
			report_error($sformatf("read %03h gave %08h resp %0d, expected %08h resp %0d",
				addr, rsp.rdata, rsp.rresp, exp_data, exp_resp));
		end
		stall = stall_en ? int'(rand_bits(3)) : 0;
		repeat (stall) @(posedge clk);
		@(posedge clk);
		req.rready <= 1'b1;
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	task automatic load_word(input int i, input word_t data);
		axil_write(ADDR_STATE_BASE + 12'(8 * i), data[31:0], RESP_OKAY);
		axil_write(ADDR_STATE_BASE + 12'(8 * i) + 12'd4, data[63:32], RESP_OKAY);
		model_state[4'(i)] = data;
	endtask

	task automatic check_state();
		for (int i = 0; i < NUM_WORDS; i++) begin
			axil_read(ADDR_STATE_BASE + 12'(8 * i), model_state[4'(i)][31:0], RESP_OKAY);
			axil_read(ADDR_STATE_BASE + 12'(8 * i) + 12'd4, model_state[4'(i)][63:32],
				RESP_OKAY);
		end
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (busy) @(negedge clk);
	endtask

	task automatic run_mix();
		axil_write(ADDR_CTRL, 32'h1, RESP_OKAY);
		if (!busy) begin
			report_error("busy_o low after an accepted start");
		end
		// status shows busy while the mix runs
		axil_read(ADDR_STATUS, 32'd1, RESP_OKAY);
		wait_idle();
		model_mix();
	endtask

	// counts the cycles of the current busy period
	always @(posedge clk) begin
		if (!rst_n || !busy) begin
			busy_cycles <= 0;
		end else begin
			busy_cycles <= busy_cycles + 1;
		end
	end

	a_busy_max: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> busy_cycles < MIX_CYCLES)
		else report_error("busy_o held longer than 8 x ROUNDS cycles");

	a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> busy_cycles == MIX_CYCLES)
		else report_error("busy_o period differs from 8 x ROUNDS cycles");

	a_bresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
		else report_error("bvalid or bresp changed before bready");

	a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
		else report_error("rvalid, rdata or rresp changed before rready");

	a_aw_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!rsp.bvalid |-> rsp.awready && rsp.wready)
		else report_error("awready or wready low with no write response pending");

	a_ar_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!rsp.rvalid |-> rsp.arready)
		else report_error("arready low with no read data pending");

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		req = '0;
		rst_n = 1'b0;
		stall_en = 1'b1;
		for (int i = 0; i < NUM_WORDS; i++) begin
			model_state[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// reset values
		check_state();
		axil_read(ADDR_STATUS, 32'd0, RESP_OKAY);

		// random load and read back
		for (int i = 0; i < NUM_WORDS; i++) begin
			load_word(i, rand_bits(64));
		end
		check_state();
		// low half alone does not commit
		axil_write(ADDR_STATE_BASE + 12'd40, ~model_state[5][31:0], RESP_OKAY);
		axil_read(ADDR_STATE_BASE + 12'd40, model_state[5][31:0], RESP_OKAY);
		axil_read(ADDR_STATE_BASE + 12'd44, model_state[5][63:32], RESP_OKAY);

		// first mix
		run_mix();
		check_state();
		axil_read(ADDR_STATUS, 32'd0, RESP_OKAY);

		// writes during a mix are refused
		stall_en = 1'b0;
		axil_write(ADDR_CTRL, 32'h1, RESP_OKAY);
		axil_write(ADDR_STATE_BASE + 12'd16, 32'h1234_5678, RESP_SLVERR);
		axil_write(ADDR_STATE_BASE + 12'd20, 32'h9abc_def0, RESP_SLVERR);
		axil_write(ADDR_CTRL, 32'h1, RESP_SLVERR);
		@(negedge clk);
		if (!busy) begin
			report_error("mix ended before the refused writes were sent");
		end
		wait_idle();
		model_mix();
		check_state();
		axil_write(12'h080, 32'hffff_ffff, RESP_SLVERR);
		axil_read(12'h200, 32'd0, RESP_SLVERR);

		// second run from the result, with stalls again
		stall_en = 1'b1;
		run_mix();
		check_state();
		axil_read(ADDR_STATUS, 32'd0, RESP_OKAY);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- blake_mix.f
blake_mix_pkg.sv
output_register_element.sv
output_register_block.sv
g_mix.sv
mix_round_ctrl.sv
axil_state_regs.sv
blake_mix_top.sv
tb_blake_mix.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_blake_mix -f blake_mix.f -o tb_blake_mix

out=$(./obj_dir/tb_blake_mix 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
